// File: src/rx_pkg.sv
package rx_pkg;

    // interleaving and code widths
    localparam int NTI    = 4;
    localparam int NADC   = 7;
    localparam int CODE_W = NADC + 1;

    // signed unfolded ADC code
    typedef logic signed [CODE_W-1:0] code_t;

    // offset calibration window, 2^navg samples
    localparam int NAVG_W = 3;
    localparam int ACC_W  = CODE_W + 7;
    // sample counter wide enough for the largest window
    localparam int SCNT_W = (1 << NAVG_W) - 1;

    // strobe divider, 2^ndiv cycles per strobe
    localparam int NDIV_W    = 3;
    localparam int DIV_CNT_W = (1 << NDIV_W) - 1;

    // PRBS7, x^7 + x^6 + 1
    localparam int NPRBS      = 7;
    localparam int PRBS_TAP_A = 7;
    localparam int PRBS_TAP_B = 6;
    localparam int CNT_W      = 32;

    // checker mode codes
    localparam logic [1:0] PRBS_IDLE  = 2'd0;
    localparam logic [1:0] PRBS_ALIGN = 2'd1;
    localparam logic [1:0] PRBS_CHECK = 2'd2;

    // burst capture memories
    localparam int MEM_DEPTH = 32;
    localparam int MEM_AW    = 5;

endpackage

// File: src/freq_divider.sv
`timescale 1ns/1ps
`default_nettype none

module freq_divider import rx_pkg::*; (
    input  wire logic              clk_adc,
    input  wire logic              rst_n_i,
    input  wire logic [NDIV_W-1:0] ndiv_i,
    output logic                   stb_o
);

    logic [DIV_CNT_W-1:0] div_cnt;
    logic [DIV_CNT_W-1:0] div_mask;

    // only the low ndiv bits take part in the wrap
    assign div_mask = ~({DIV_CNT_W{1'b1}} << ndiv_i);

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // one-cycle pulse each time the masked count is all ones
    // ndiv of zero gives an empty mask, so strobe every cycle
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stb_o <= 1'b0;
        end else begin
            stb_o <= ((div_cnt & div_mask) == div_mask);
        end
    end

endmodule

`default_nettype wire

// File: src/adc_unfolding.sv
`timescale 1ns/1ps
`default_nettype none

module adc_unfolding import rx_pkg::*; (
    input  wire logic              clk_adc,
    input  wire logic              rst_n_i,
    input  wire logic              avg_stb_i,
    input  wire logic [NADC-1:0]   din_i,
    input  wire logic              sign_i,
    input  wire logic              en_pfd_cal_i,
    input  wire logic              en_ext_offset_i,
    input  wire code_t             ext_offset_i,
    input  wire logic [NAVG_W-1:0] navg_i,
    output code_t                  dout_o,
    output code_t                  pfd_offset_o
);

    code_t                    raw_code;
    code_t                    active_offset;
    code_t                    cal_offset;
    logic signed [ACC_W-1:0]  acc;
    logic signed [ACC_W-1:0]  acc_sum;
    logic signed [ACC_W-1:0]  acc_avg;
    logic [SCNT_W-1:0]        sample_cnt;
    logic [SCNT_W-1:0]        last_sample;

    // sign high means positive magnitude
    assign raw_code = sign_i ? code_t'({1'b0, din_i}) : -code_t'({1'b0, din_i});

    assign active_offset = en_ext_offset_i ? ext_offset_i : cal_offset;

    // window closes on sample 2^navg - 1
    assign last_sample = ~({SCNT_W{1'b1}} << navg_i);

    assign acc_sum = acc + ACC_W'(raw_code);
    assign acc_avg = acc_sum >>> navg_i;

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dout_o <= '0;
        end else begin
            dout_o <= raw_code - active_offset;
        end
    end

    // averaging calibration, paced by the divider strobe
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc        <= '0;
            sample_cnt <= '0;
            cal_offset <= '0;
        end else if (!en_pfd_cal_i) begin
            // keep the last result, restart the window
            acc        <= '0;
            sample_cnt <= '0;
        end else if (avg_stb_i) begin
            if (sample_cnt == last_sample) begin
                cal_offset <= acc_avg[CODE_W-1:0];
                acc        <= '0;
                sample_cnt <= '0;
            end else begin
                acc        <= acc_sum;
                sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

    assign pfd_offset_o = cal_offset;

endmodule

`default_nettype wire

// File: src/comb_comp.sv
`timescale 1ns/1ps
`default_nettype none

module comb_comp import rx_pkg::*; (
    input  wire logic           clk_adc,
    input  wire logic           rst_n_i,
    input  wire code_t          codes_i [NTI],
    input  wire code_t          thresh_i,
    output logic [NTI-1:0]      bits_o
);

    logic [NTI-1:0] decisions;

    // signed compare per lane
    always_comb begin
        for (int k = 0; k < NTI; k++) begin
            decisions[k] = (codes_i[k] > thresh_i);
        end
    end

    // one register stage before the checker
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= decisions;
        end
    end

endmodule

`default_nettype wire

// File: src/prbs_checker.sv
`timescale 1ns/1ps
`default_nettype none

module prbs_checker import rx_pkg::*; (
    input  wire logic             clk_adc,
    input  wire logic             rst_n_i,
    input  wire logic [1:0]       mode_i,
    input  wire logic [NTI-1:0]   rx_bits_i,
    output logic [CNT_W-1:0]      correct_bits_o,
    output logic [CNT_W-1:0]      total_bits_o
);

    // bit 0 holds the newest bit of the history
    logic [NPRBS-1:0] prbs_state;
    logic [NPRBS-1:0] prbs_state_next;
    logic [NPRBS-1:0] rx_hist;
    logic [NPRBS-1:0] rx_hist_next;
    logic [NTI-1:0]   pred_bits;
    logic [CNT_W-1:0] n_match;

    // shift received lanes in, oldest lane first
    always_comb begin
        rx_hist_next = rx_hist;
        for (int k = 0; k < NTI; k++) begin
            rx_hist_next = {rx_hist_next[NPRBS-2:0], rx_bits_i[k]};
        end
    end

    // unrolled recurrence, b[n] = b[n-7] ^ b[n-6]
    always_comb begin
        logic new_bit;
        prbs_state_next = prbs_state;
        for (int k = 0; k < NTI; k++) begin
            new_bit = prbs_state_next[PRBS_TAP_A-1] ^ prbs_state_next[PRBS_TAP_B-1];
            pred_bits[k] = new_bit;
            prbs_state_next = {prbs_state_next[NPRBS-2:0], new_bit};
        end
    end

    always_comb begin
        n_match = '0;
        for (int k = 0; k < NTI; k++) begin
            if (pred_bits[k] == rx_bits_i[k]) begin
                n_match = n_match + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_hist <= '0;
        end else begin
            rx_hist <= rx_hist_next;
        end
    end

    // state seeds from the link in align, runs free in check
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prbs_state <= '0;
        end else if (mode_i == PRBS_ALIGN) begin
            prbs_state <= rx_hist_next;
        end else if (mode_i == PRBS_CHECK) begin
            prbs_state <= prbs_state_next;
        end
    end

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            correct_bits_o <= '0;
            total_bits_o   <= '0;
        end else begin
            case (mode_i)
                PRBS_CHECK: begin
                    correct_bits_o <= correct_bits_o + n_match;
                    total_bits_o   <= total_bits_o + CNT_W'(NTI);
                end
                PRBS_ALIGN: begin
                    // counters hold while seeding
                    correct_bits_o <= correct_bits_o;
                    total_bits_o   <= total_bits_o;
                end
                default: begin
                    correct_bits_o <= '0;
                    total_bits_o   <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/oneshot_memory.sv
`timescale 1ns/1ps
`default_nettype none

module oneshot_memory import rx_pkg::*; #(
    parameter type word_t = logic
) (
    input  wire logic              clk_adc,
    input  wire logic              rst_n_i,
    input  wire logic              start_i,
    input  wire word_t             wr_data_i [NTI],
    input  wire logic [MEM_AW-1:0] rd_addr_i,
    output word_t                  rd_data_o [NTI],
    output logic                   busy_o
);

    word_t             mem [MEM_DEPTH][NTI];
    logic [MEM_AW-1:0] wr_addr;
    logic              last_addr;

    assign last_addr = (wr_addr == MEM_AW'(MEM_DEPTH - 1));

    // start pulse is ignored while busy
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_o  <= 1'b0;
            wr_addr <= '0;
        end else if (!busy_o) begin
            if (start_i) begin
                busy_o  <= 1'b1;
                wr_addr <= '0;
            end
        end else begin
            if (last_addr) begin
                busy_o <= 1'b0;
            end
            wr_addr <= wr_addr + 1'b1;
        end
    end

    // one row of NTI words per burst cycle
    always_ff @(posedge clk_adc) begin
        if (busy_o) begin
            for (int k = 0; k < NTI; k++) begin
                mem[wr_addr][k] <= wr_data_i[k];
            end
        end
    end

    // registered read port
    always_ff @(posedge clk_adc) begin
        for (int k = 0; k < NTI; k++) begin
            rd_data_o[k] <= mem[rd_addr_i][k];
        end
    end

endmodule

`default_nettype wire

// File: src/rx_digital_core.sv
`timescale 1ns/1ps
`default_nettype none

module rx_digital_core import rx_pkg::*; (
    input  wire logic              clk_adc,
    input  wire logic              rst_n_i,
    // ADC slices
    input  wire logic [NADC-1:0]   adcout_i [NTI],
    input  wire logic [NTI-1:0]    adcout_sign_i,
    // offset calibration
    input  wire logic              en_pfd_cal_i,
    input  wire logic              en_ext_offset_i,
    input  wire code_t             ext_offset_i [NTI],
    input  wire logic [NAVG_W-1:0] navg_i,
    input  wire logic [NDIV_W-1:0] ndiv_i,
    output code_t                  pfd_offset_o [NTI],
    // slicer and PRBS checker
    input  wire code_t             thresh_i,
    input  wire logic [1:0]        prbs_mode_i,
    output logic [CNT_W-1:0]       correct_bits_o,
    output logic [CNT_W-1:0]       total_bits_o,
    // capture memories
    input  wire logic              dump_start_i,
    input  wire logic [MEM_AW-1:0] mem_addr_i,
    output code_t                  mem_codes_o [NTI],
    output logic [NTI-1:0]         mem_bits_o,
    output logic                   dump_busy_o
);

    logic           avg_stb;
    code_t          code [NTI];
    logic [NTI-1:0] rx_bits;
    logic           rx_bit_lane [NTI];
    logic           mem_bit_lane [NTI];

    // calibration sample pacing
    freq_divider avg_div_i (
        .clk_adc (clk_adc),
        .rst_n_i (rst_n_i),
        .ndiv_i  (ndiv_i),
        .stb_o   (avg_stb)
    );

    genvar k;
    generate
        for (k = 0; k < NTI; k++) begin : g_slice
            adc_unfolding unfold_i (
                .clk_adc         (clk_adc),
                .rst_n_i         (rst_n_i),
                .avg_stb_i       (avg_stb),
                .din_i           (adcout_i[k]),
                .sign_i          (adcout_sign_i[k]),
                .en_pfd_cal_i    (en_pfd_cal_i),
                .en_ext_offset_i (en_ext_offset_i),
                .ext_offset_i    (ext_offset_i[k]),
                .navg_i          (navg_i),
                .dout_o          (code[k]),
                .pfd_offset_o    (pfd_offset_o[k])
            );

            // lane split for the bit memory
            assign rx_bit_lane[k] = rx_bits[k];
            assign mem_bits_o[k]  = mem_bit_lane[k];
        end
    endgenerate

    comb_comp comp_i (
        .clk_adc  (clk_adc),
        .rst_n_i  (rst_n_i),
        .codes_i  (code),
        .thresh_i (thresh_i),
        .bits_o   (rx_bits)
    );

    prbs_checker prbs_i (
        .clk_adc        (clk_adc),
        .rst_n_i        (rst_n_i),
        .mode_i         (prbs_mode_i),
        .rx_bits_i      (rx_bits),
        .correct_bits_o (correct_bits_o),
        .total_bits_o   (total_bits_o)
    );

    // both memories start on the same pulse and stay in step
    oneshot_memory #(.word_t(code_t)) mem_codes_i (
        .clk_adc   (clk_adc),
        .rst_n_i   (rst_n_i),
        .start_i   (dump_start_i),
        .wr_data_i (code),
        .rd_addr_i (mem_addr_i),
        .rd_data_o (mem_codes_o),
        .busy_o    (dump_busy_o)
    );

    oneshot_memory #(.word_t(logic)) mem_bits_i (
        .clk_adc   (clk_adc),
        .rst_n_i   (rst_n_i),
        .start_i   (dump_start_i),
        .wr_data_i (rx_bit_lane),
        .rd_addr_i (mem_addr_i),
        .rd_data_o (mem_bit_lane),
        .busy_o    ()
    );

endmodule

`default_nettype wire

// File: bench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release away from the clock edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

// File: bench/tb_rx_digital_core.sv
`timescale 1ns/1ps

module tb_rx_digital_core import rx_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    localparam int NSAMP       = MEM_DEPTH + 6;
    localparam int START_IDX   = 2;
    localparam int EXTRA_IDX   = 12;
    localparam int BURST_CYC   = NSAMP + 2 * MEM_DEPTH + 2;
    localparam int TEST_CYCLES = 3 * BURST_CYC + 30 + 60 + 10;
    localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

    logic              clk;
    logic              rst_n;
    logic [NADC-1:0]   adcout [NTI];
    logic [NTI-1:0]    adcout_sign;
    logic              en_pfd_cal;
    logic              en_ext_offset;
    code_t             ext_offset [NTI];
    logic [NAVG_W-1:0] navg;
    logic [NDIV_W-1:0] ndiv;
    code_t             pfd_offset [NTI];
    code_t             thresh;
    logic [1:0]        prbs_mode;
    logic [CNT_W-1:0]  correct_bits;
    logic [CNT_W-1:0]  total_bits;
    logic              dump_start;
    logic [MEM_AW-1:0] mem_addr;
    code_t             mem_codes [NTI];
    logic [NTI-1:0]    mem_bits;
    logic              dump_busy;

    // stimulus per burst and memory contents read back
    logic [NADC-1:0]   samp_mag [NSAMP][NTI];
    logic              samp_sign [NSAMP][NTI];
    code_t             rd_codes [MEM_DEPTH][NTI];
    logic              rd_bits [MEM_DEPTH][NTI];

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) i_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rx_digital_core i_dut (
        .clk_adc         (clk),
        .rst_n_i         (rst_n),
        .adcout_i        (adcout),
        .adcout_sign_i   (adcout_sign),
        .en_pfd_cal_i    (en_pfd_cal),
        .en_ext_offset_i (en_ext_offset),
        .ext_offset_i    (ext_offset),
        .navg_i          (navg),
        .ndiv_i          (ndiv),
        .pfd_offset_o    (pfd_offset),
        .thresh_i        (thresh),
        .prbs_mode_i     (prbs_mode),
        .correct_bits_o  (correct_bits),
        .total_bits_o    (total_bits),
        .dump_start_i    (dump_start),
        .mem_addr_i      (mem_addr),
        .mem_codes_o     (mem_codes),
        .mem_bits_o      (mem_bits),
        .dump_busy_o     (dump_busy)
    );

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    // outputs are sampled and inputs driven here
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // sign high is plus magnitude and the offset comes off after
    function automatic code_t expected_code(input logic sgn, input logic [NADC-1:0] mag,
                                            input code_t off);
        int value;
        value = sgn ? int'(mag) : -int'(mag);
        value = value - int'(off);
        return code_t'(value);
    endfunction

    task automatic fill_random_samples();
        for (int s = 0; s < NSAMP; s++) begin
            for (int k = 0; k < NTI; k++) begin
                samp_mag[s][k]  = NADC'($urandom_range(127));
                samp_sign[s][k] = 1'($urandom_range(1));
            end
        end
    endtask

    // code row a holds sample START_IDX + a
    // bit row a holds the sample before it
    task automatic capture_burst(input bit extra_pulse);
        int busy_cnt;
        busy_cnt = 0;
        for (int s = 0; s < NSAMP; s++) begin
            next_cycle();
            if (dump_busy) begin
                busy_cnt++;
            end
            if (s == START_IDX + 1) begin
                assert (dump_busy)
                else report_mismatch("dump_busy_o low in the cycle after the start pulse");
            end
            for (int k = 0; k < NTI; k++) begin
                adcout[k]      = samp_mag[s][k];
                adcout_sign[k] = samp_sign[s][k];
            end
            dump_start = (s == START_IDX) || (extra_pulse && (s == EXTRA_IDX));
        end
        next_cycle();
        assert (!dump_busy) else report_mismatch("dump_busy_o still high after the burst");
        assert (busy_cnt == MEM_DEPTH)
        else report_mismatch($sformatf("dump_busy_o high for %0d cycles, expected %0d",
                                       busy_cnt, MEM_DEPTH));
    endtask

    task automatic read_memories();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            next_cycle();
            mem_addr = MEM_AW'(a);
            next_cycle();
            for (int k = 0; k < NTI; k++) begin
                rd_codes[a][k] = mem_codes[k];
                rd_bits[a][k]  = mem_bits[k];
            end
        end
    endtask

    task automatic check_reset_state();
        assert (!dump_busy) else report_mismatch("dump_busy_o high after reset");
        assert (correct_bits == '0) else report_mismatch("correct_bits_o not zero after reset");
        assert (total_bits == '0) else report_mismatch("total_bits_o not zero after reset");
        for (int k = 0; k < NTI; k++) begin
            assert (i_dut.code[k] == '0)
            else report_mismatch($sformatf("code of slice %0d not zero after reset", k));
        end
    endtask

    task automatic check_ext_offset();
        en_ext_offset = 1'b1;
        for (int k = 0; k < NTI; k++) begin
            ext_offset[k] = code_t'($urandom_range(255));
        end
        fill_random_samples();
        capture_burst(1'b0);
        read_memories();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            for (int k = 0; k < NTI; k++) begin
                assert (rd_codes[a][k] == expected_code(samp_sign[START_IDX + a][k],
                                                        samp_mag[START_IDX + a][k],
                                                        ext_offset[k]))
                else report_mismatch($sformatf("code addr %0d slice %0d is %0d", a, k,
                                               rd_codes[a][k]));
            end
        end
        for (int k = 0; k < NTI; k++) begin
            assert (pfd_offset[k] == code_t'(0))
            else report_mismatch($sformatf("pfd_offset_o[%0d] moved without calibration", k));
        end
    endtask

    task automatic check_calibration();
        logic [NADC-1:0] mag [NTI];
        logic            sgn [NTI];
        next_cycle();
        en_ext_offset = 1'b0;
        en_pfd_cal    = 1'b1;
        ndiv          = 3'd1;
        navg          = 3'd3;
        for (int k = 0; k < NTI; k++) begin
            mag[k]         = NADC'($urandom_range(127));
            sgn[k]         = 1'($urandom_range(1));
            adcout[k]      = mag[k];
            adcout_sign[k] = sgn[k];
        end
        // one window of 2^(ndiv+navg) cycles plus divider phase slack
        repeat (24) next_cycle();
        for (int k = 0; k < NTI; k++) begin
            assert (pfd_offset[k] == expected_code(sgn[k], mag[k], code_t'(0)))
            else report_mismatch($sformatf("pfd_offset_o[%0d] is %0d", k, pfd_offset[k]));
        end
        for (int s = 0; s < NSAMP; s++) begin
            for (int k = 0; k < NTI; k++) begin
                samp_mag[s][k]  = mag[k];
                samp_sign[s][k] = sgn[k];
            end
        end
        capture_burst(1'b0);
        read_memories();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            for (int k = 0; k < NTI; k++) begin
                assert (rd_codes[a][k] == code_t'(0))
                else report_mismatch($sformatf("calibrated code addr %0d slice %0d is %0d",
                                               a, k, rd_codes[a][k]));
            end
        end
        en_pfd_cal = 1'b0;
    endtask

    task automatic check_slicing();
        logic exp_bit;
        int   idx;
        en_ext_offset = 1'b1;
        for (int k = 0; k < NTI; k++) begin
            ext_offset[k] = code_t'(0);
        end
        thresh = code_t'(int'($urandom_range(80)) - 40);
        fill_random_samples();
        // second start pulse lands inside the burst
        capture_burst(1'b1);
        read_memories();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            idx = START_IDX + a - 1;
            for (int k = 0; k < NTI; k++) begin
                exp_bit = expected_code(samp_sign[idx][k], samp_mag[idx][k], code_t'(0))
                          > thresh;
                assert (rd_bits[a][k] == exp_bit)
                else report_mismatch($sformatf("bit addr %0d lane %0d is %0b", a, k,
                                               rd_bits[a][k]));
            end
        end
    endtask

    task automatic check_prbs_counting();
        logic             prbs_q [$];
        logic [NPRBS-1:0] seed;
        logic             new_bit;
        logic             flip;
        int               n_check;
        n_check = 0;
        thresh  = code_t'(0);
        seed    = NPRBS'($urandom_range(127, 1));
        for (int i = NPRBS - 1; i >= 0; i--) begin
            prbs_q.push_back(seed[i]);
        end
        // samples reach the checker two cycles after they are driven
        for (int m = 0; m < 58; m++) begin
            next_cycle();
            if (m == 56) begin
                assert (total_bits == CNT_W'(NTI * n_check))
                else report_mismatch($sformatf("total_bits_o is %0d", total_bits));
                assert (correct_bits == CNT_W'(NTI * n_check - 3))
                else report_mismatch($sformatf("correct_bits_o is %0d", correct_bits));
            end
            if (m == 57) begin
                assert (total_bits == '0 && correct_bits == '0)
                else report_mismatch("counters not cleared in idle mode");
            end
            // lane 0 is the oldest bit of the cycle
            for (int k = 0; k < NTI; k++) begin
                new_bit = prbs_q[prbs_q.size() - 7] ^ prbs_q[prbs_q.size() - 6];
                prbs_q.push_back(new_bit);
                flip = (m == 10 || m == 25 || m == 40) && (k == m % NTI);
                adcout[k]      = NADC'(40);
                adcout_sign[k] = new_bit ^ flip;
            end
            if (m >= 2 && m < 6) begin
                prbs_mode = PRBS_ALIGN;
            end else if (m >= 6 && m < 56) begin
                prbs_mode = PRBS_CHECK;
                n_check++;
            end else begin
                prbs_mode = PRBS_IDLE;
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog timeout: the tests did not finish in time");
    end

    initial begin
        void'($urandom(32'h9a2d));
        adcout_sign   = '0;
        en_pfd_cal    = 1'b0;
        en_ext_offset = 1'b0;
        navg          = '0;
        ndiv          = '0;
        thresh        = code_t'(0);
        prbs_mode     = PRBS_IDLE;
        dump_start    = 1'b0;
        mem_addr      = '0;
        for (int k = 0; k < NTI; k++) begin
            adcout[k]     = '0;
            ext_offset[k] = code_t'(0);
        end
        wait (rst_n == 1'b1);
        next_cycle();
        check_reset_state();
        check_ext_offset();
        check_calibration();
        check_slicing();
        check_prbs_counting();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: filelist.f
src/rx_pkg.sv
src/freq_divider.sv
src/adc_unfolding.sv
src/comb_comp.sv
src/prbs_checker.sv
src/oneshot_memory.sv
src/rx_digital_core.sv
bench/tb_clkgen.sv
bench/tb_rx_digital_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass is decided from the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_rx_digital_core \
    -f filelist.f && \
./obj_dir/Vtb_rx_digital_core | tee /dev/stderr | grep -q -F '*** TEST PASSED ***' && \
{ echo "simulation passed"; exit 0; } || \
{ echo "simulation failed"; exit 1; }
